/* hdl/video_pkg.sv */
package video_pkg;

	// horizontal timing in 7 MHz dots
	localparam logic [8:0] HPERIOD      = 9'd448; // dots per line
	localparam logic [8:0] HBLNK_BEG    = 9'd0;   // visible line ends here
	localparam logic [8:0] HBLNK_END    = 9'd88;
	localparam logic [8:0] HSYNC_BEG    = 9'd10;
	localparam logic [8:0] HSYNC_END    = 9'd43;  // 33 dots of sync
	localparam logic [8:0] HPIX_BEG_256 = 9'd140; // 52 dots of border each side
	localparam logic [8:0] HPIX_END_256 = 9'd396;
	localparam logic [8:0] HPIX_BEG_320 = 9'd108; // 20 dots of border each side
	localparam logic [8:0] HPIX_END_320 = 9'd428;
	localparam logic [8:0] HPIX_BEG_360 = 9'd88;  // no border
	localparam logic [8:0] HPIX_END_360 = 9'd448; // ends at the line wrap
	// fetch must run ahead of the pixel output
	localparam logic [8:0] FETCH_PRE_ZX = 9'd18;
	localparam logic [8:0] FETCH_PRE_TM = 9'd10;
	localparam logic [8:0] TFETCH_LEN   = 9'd32;  // 16 words of tile data
	localparam logic [8:0] XSFETCH_LEN  = 9'd4;   // 2 words of Xscroll data
	localparam logic [8:0] SCANIN_BEG   = 9'd88;  // scan doubler starts storing
	localparam logic [8:0] HINT_BEG     = 9'd445; // fine position of the INT

	// vertical timing in lines
	localparam logic [8:0] VPERIOD     = 9'd320;
	localparam logic [8:0] VBLNK_BEG   = 9'd0;
	localparam logic [8:0] VBLNK_END   = 9'd32;
	localparam logic [8:0] VSYNC_BEG   = 9'd4;
	localparam logic [8:0] VSYNC_END   = 9'd8;
	localparam logic [8:0] VPIX_BEG    = 9'd76;  // 192 lines of graphics
	localparam logic [8:0] VPIX_END    = 9'd268;
	localparam logic [8:0] VTFETCH_BEG = 9'd75;  // tiles are fetched a line early
	localparam logic [8:0] VTFETCH_END = 9'd267;

	// wishbone word addresses
	localparam logic       REG_MODE     = 1'b0;
	localparam logic       REG_INT_LINE = 1'b1;
	localparam logic [8:0] INT_LINE_RST = 9'd0;

	typedef enum logic [1:0]
	{
		RRES_256  = 2'b00,
		RRES_320A = 2'b01,
		RRES_320B = 2'b10,
		RRES_360  = 2'b11
	} rres_t;

	typedef struct packed
	{
		rres_t      rres;
		logic       mode_tm;  // tiles mode
		logic       mode_brd; // border only, no linear graphics
		logic       xints_en; // Xscroll interrupts
		logic [8:0] int_line;
	} video_cfg_t;

	typedef struct packed
	{
		logic hblank;
		logic hsync;
		logic hpix;
		logic fetch_gfx_win;  // raw windows, gated later
		logic fetch_tile_win;
		logic fetch_xs_win;
		logic line_start;
		logic hsync_start;
		logic hint_start;
		logic scanin_start;
		logic line_tick;      // last dot of the line
	} h_timing_t;

	typedef struct packed
	{
		logic vblank;
		logic vsync;
		logic vpix;
		logic vtfetch;
		logic int_line_hit;
	} v_timing_t;

	typedef struct packed
	{
		logic blank;
		logic hsync;
		logic vsync;
		logic pix;
		logic fetch_gfx;
		logic fetch_tile;
		logic fetch_xs;
		logic line_start;
		logic hsync_start;
		logic scanin_start;
		logic hint_start;
		logic frame_int;
		logic vpix;
	} video_out_t;

endpackage

/* hdl/video_cfg_regs.sv */
module video_cfg_regs (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_adr,   // word address
	input  logic [15:0]           wb_dat_w,
	output logic [15:0]           wb_dat_r,
	output logic                  wb_ack,
	output video_pkg::video_cfg_t cfg
);

	logic access; // classic cycle accepted this clock

	// one ack per strobe, the master drops stb after seeing it
	assign access = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;
	end

	// writes land on the same edge that raises ack
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cfg.rres     <= video_pkg::RRES_256;
			cfg.mode_tm  <= 1'b0;
			cfg.mode_brd <= 1'b0;
			cfg.xints_en <= 1'b0;
			cfg.int_line <= video_pkg::INT_LINE_RST;
		end
		else if (access && wb_we)
		begin
			case (wb_adr)
				video_pkg::REG_MODE:
				begin
					cfg.rres     <= video_pkg::rres_t'(wb_dat_w[1:0]); // raster width
					cfg.mode_tm  <= wb_dat_w[2];
					cfg.mode_brd <= wb_dat_w[3];
					cfg.xints_en <= wb_dat_w[4];
				end
				default: // REG_INT_LINE
					cfg.int_line <= wb_dat_w[8:0];
			endcase
		end
	end

	// read data is steady while the master holds the address
	always_comb
	begin
		wb_dat_r = '0;
		case (wb_adr)
			video_pkg::REG_MODE:
				wb_dat_r[4:0] = {cfg.xints_en, cfg.mode_brd, cfg.mode_tm, cfg.rres};
			default:
				wb_dat_r[8:0] = cfg.int_line; // unused upper bits read as zero
		endcase
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held for two clocks");

endmodule

/* hdl/video_sync_h.sv */
module video_sync_h (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  cend,     // 7 MHz dot strobe
	input  logic                  pre_cend, // clock before cend
	input  video_pkg::video_cfg_t cfg,
	output video_pkg::h_timing_t  h
);

	logic [8:0] hcount;  // dot position in line
	logic [8:0] hp_beg;  // pixel window for the selected width
	logic [8:0] hp_end;
	logic [8:0] f_pre;   // fetch lead
	logic [8:0] gfx_beg;
	logic [8:0] gfx_end;
	logic       hblank;
	logic       hsync;
	logic       hpix;
	logic       fetch_gfx_win;
	logic       fetch_tile_win;
	logic       fetch_xs_win;
	logic       line_start;
	logic       hsync_start;
	logic       hint_start;
	logic       scanin_start;
	logic       line_tick;

	// positions at or past the period close at the wrap
	function automatic logic [8:0] wrap(input logic [8:0] pos);
		return (pos >= video_pkg::HPERIOD) ? pos - video_pkg::HPERIOD : pos;
	endfunction

	always_comb
	begin
		case (cfg.rres)
			video_pkg::RRES_256:
			begin
				hp_beg = video_pkg::HPIX_BEG_256;
				hp_end = video_pkg::HPIX_END_256;
			end
			video_pkg::RRES_320A, video_pkg::RRES_320B:
			begin
				hp_beg = video_pkg::HPIX_BEG_320;
				hp_end = video_pkg::HPIX_END_320;
			end
			default: // 360 wide
			begin
				hp_beg = video_pkg::HPIX_BEG_360;
				hp_end = video_pkg::HPIX_END_360;
			end
		endcase
	end

	assign f_pre   = cfg.mode_tm ? video_pkg::FETCH_PRE_TM : video_pkg::FETCH_PRE_ZX;
	assign gfx_beg = wrap(hp_beg - f_pre);
	assign gfx_end = wrap(hp_end - f_pre);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcount    <= '0;
			line_tick <= 1'b0;
		end
		else if (cend)
		begin
			hcount    <= (hcount == video_pkg::HPERIOD - 9'd1) ? 9'd0 : hcount + 9'd1;
			line_tick <= (hcount == video_pkg::HPERIOD - 9'd2); // next dot is the last
		end
	end

	// windows open at begin and close at end, both on cend
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hblank         <= 1'b0;
			hsync          <= 1'b0;
			hpix           <= 1'b0;
			fetch_gfx_win  <= 1'b0;
			fetch_tile_win <= 1'b0;
			fetch_xs_win   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == video_pkg::HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == video_pkg::HBLNK_END)
				hblank <= 1'b0;
			if (hcount == video_pkg::HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == video_pkg::HSYNC_END)
				hsync <= 1'b0;
			if (hcount == hp_beg)
				hpix <= 1'b1;
			else if (hcount == wrap(hp_end))
				hpix <= 1'b0;
			if (hcount == gfx_beg)
				fetch_gfx_win <= 1'b1;
			else if (hcount == gfx_end)
				fetch_gfx_win <= 1'b0;
			// tiles start 2 dots into sync, Xscrolls follow right after
			if (hcount == video_pkg::HSYNC_BEG + 9'd2)
				fetch_tile_win <= 1'b1;
			else if (hcount == video_pkg::HSYNC_BEG + 9'd2 + video_pkg::TFETCH_LEN)
				fetch_tile_win <= 1'b0;
			fetch_xs_win <= (hcount >= video_pkg::HSYNC_BEG + 9'd2 + video_pkg::TFETCH_LEN)
				&& (hcount < video_pkg::HSYNC_BEG + 9'd2 + video_pkg::TFETCH_LEN
				+ video_pkg::XSFETCH_LEN);
		end
	end

	// strobes sit in the cend clock of their dot
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			line_start   <= 1'b0;
			hsync_start  <= 1'b0;
			hint_start   <= 1'b0;
			scanin_start <= 1'b0;
		end
		else
		begin
			line_start   <= pre_cend && (hcount == video_pkg::HBLNK_END);
			hsync_start  <= pre_cend && (hcount == video_pkg::HSYNC_BEG);
			hint_start   <= pre_cend && (hcount == video_pkg::HINT_BEG);
			scanin_start <= pre_cend && (hcount == video_pkg::SCANIN_BEG);
		end
	end

	assign h = '{hblank: hblank, hsync: hsync, hpix: hpix,
		fetch_gfx_win: fetch_gfx_win, fetch_tile_win: fetch_tile_win,
		fetch_xs_win: fetch_xs_win, line_start: line_start,
		hsync_start: hsync_start, hint_start: hint_start,
		scanin_start: scanin_start, line_tick: line_tick};

	a_hcount_range: assert property (@(posedge clk) disable iff (!arst_n)
		hcount < video_pkg::HPERIOD)
		else $error("hcount out of range");

	a_hsync_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
		hsync |-> hblank)
		else $error("hsync outside horizontal blank");

endmodule

/* hdl/video_sync_v.sv */
module video_sync_v (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  cend,
	input  logic                  line_tick, // last dot of the line
	input  video_pkg::video_cfg_t cfg,
	output video_pkg::v_timing_t  v
);

	logic [8:0] vcount; // current line
	logic [8:0] vnext;  // line that starts at the next tick

	function automatic logic in_win(
		input logic [8:0] line,
		input logic [8:0] beg,
		input logic [8:0] fin
	);
		return (line >= beg) && (line < fin);
	endfunction

	assign vnext = (vcount == video_pkg::VPERIOD - 9'd1) ? 9'd0 : vcount + 9'd1;

	// everything moves together at the line wrap
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vcount <= '0;
			v      <= '0;
		end
		else if (cend && line_tick)
		begin
			vcount         <= vnext;
			v.vblank       <= in_win(vnext, video_pkg::VBLNK_BEG, video_pkg::VBLNK_END);
			v.vsync        <= in_win(vnext, video_pkg::VSYNC_BEG, video_pkg::VSYNC_END);
			v.vpix         <= in_win(vnext, video_pkg::VPIX_BEG, video_pkg::VPIX_END);
			v.vtfetch      <= in_win(vnext, video_pkg::VTFETCH_BEG, video_pkg::VTFETCH_END);
			v.int_line_hit <= (vnext == cfg.int_line); // whole line of the INT
		end
	end

	a_vcount_range: assert property (@(posedge clk) disable iff (!arst_n)
		vcount < video_pkg::VPERIOD)
		else $error("vcount out of range");

endmodule

/* hdl/video_sync_combine.sv */
module video_sync_combine (
	input  video_pkg::h_timing_t  h,
	input  video_pkg::v_timing_t  v,
	input  video_pkg::video_cfg_t cfg,
	output video_pkg::video_out_t vid
);

	always_comb
	begin
		vid.blank = h.hblank | v.vblank;
		vid.hsync = h.hsync;
		vid.vsync = v.vsync;
		vid.pix   = h.hpix & v.vpix;   // visible graphics area
		vid.vpix  = v.vpix;

		// linear graphics only inside the vertical window and not in border mode
		vid.fetch_gfx  = h.fetch_gfx_win & v.vpix & ~cfg.mode_brd;
		vid.fetch_tile = h.fetch_tile_win & v.vtfetch & cfg.mode_tm; // tiles mode only
		vid.fetch_xs   = h.fetch_xs_win & (cfg.mode_tm | cfg.xints_en);

		vid.line_start   = h.line_start;
		vid.hsync_start  = h.hsync_start;
		vid.scanin_start = h.scanin_start;
		vid.hint_start   = h.hint_start;

		// one pulse per frame at the fine INT position
		vid.frame_int = h.hint_start & v.int_line_hit;
	end

endmodule

/* hdl/video_timing_top.sv */
module video_timing_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  cend,     // 7 MHz strobe from the DRAM controller
	input  logic                  pre_cend,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_adr,
	input  logic [15:0]           wb_dat_w,
	output logic [15:0]           wb_dat_r,
	output logic                  wb_ack,
	output video_pkg::video_out_t vid
);

	video_pkg::video_cfg_t cfg; // mode registers
	video_pkg::h_timing_t  h;
	video_pkg::v_timing_t  v;

	video_cfg_regs u_cfg_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.cfg      (cfg)
	);

	video_sync_h u_sync_h (
		.clk      (clk),
		.arst_n   (arst_n),
		.cend     (cend),
		.pre_cend (pre_cend),
		.cfg      (cfg),
		.h        (h)
	);

	// vertical side steps on the horizontal line tick
	video_sync_v u_sync_v (
		.clk       (clk),
		.arst_n    (arst_n),
		.cend      (cend),
		.line_tick (h.line_tick),
		.cfg       (cfg),
		.v         (v)
	);

	video_sync_combine u_combine (
		.h   (h),
		.v   (v),
		.cfg (cfg),
		.vid (vid)
	);

endmodule

/* verification/tb_clk_gen.sv */
module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// release away from both edges, after 4 cycles
	initial
	begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#25 arst_n = 1'b1;
	end

endmodule

/* verification/tb_video_timing.sv */
module tb_video_timing;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROWS       = 5;
	localparam int LINE_DOTS  = int'(video_pkg::HPERIOD);
	localparam int FRAME_LNS  = int'(video_pkg::VPERIOD);
	localparam int FRAME_CLKS = LINE_DOTS * FRAME_LNS * 2; // cend every second clock
	// each row waits up to a frame for the wrap, then measures one, plus a spare
	localparam int TIMEOUT_CLKS = (2 * ROWS + 1) * FRAME_CLKS;
	localparam int VPIX_LINES   = int'(video_pkg::VPIX_END - video_pkg::VPIX_BEG);

	typedef struct packed
	{
		video_pkg::rres_t rres;
		logic             tm;
		logic             brd;
		logic             xen;
		logic [8:0]       int_line;
	} row_t;

	logic                  clk;
	logic                  arst_n;
	logic                  cend;
	logic                  pre_cend;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic                  wb_adr;
	logic [15:0]           wb_dat_w;
	logic [15:0]           wb_dat_r;
	logic                  wb_ack;
	video_pkg::video_out_t vid;

	row_t table_rows [ROWS];
	row_t cur;          // row under test
	logic phase;        // 0 drives pre_cend, 1 drives cend
	int   dot;          // dot the next cend processes
	int   line;
	logic arm;          // start measuring at the next frame start
	logic measure;
	int   cycles;
	int   cnt_pix, cnt_gfx, cnt_tile, cnt_xs, cnt_vsync, cnt_hs, cnt_ls, cnt_int;
	event frame_done;

	tb_clk_gen u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	video_timing_top u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.cend     (cend),
		.pre_cend (pre_cend),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.vid      (vid)
	);

	function automatic bit inside_span(input int pos, input int beg, input int fin);
		return (pos >= beg) && (pos < fin);
	endfunction

	function automatic int left_edge(input video_pkg::rres_t r);
		case (r)
			video_pkg::RRES_256: return int'(video_pkg::HPIX_BEG_256);
			video_pkg::RRES_360: return int'(video_pkg::HPIX_BEG_360);
			default:             return int'(video_pkg::HPIX_BEG_320); // both 320 codes
		endcase
	endfunction

	function automatic int right_edge(input video_pkg::rres_t r);
		case (r)
			video_pkg::RRES_256: return int'(video_pkg::HPIX_END_256);
			video_pkg::RRES_360: return int'(video_pkg::HPIX_END_360);
			default:             return int'(video_pkg::HPIX_END_320);
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// d is the dot of the coming cend, windows still show the dot before it
	task automatic compare_dot(input int d, input int l);
		int                    dp;
		int                    hbeg;
		int                    hend;
		int                    pre;
		int                    tbeg;
		int                    tend;
		video_pkg::video_out_t e;
		dp   = (d == 0) ? LINE_DOTS - 1 : d - 1;
		hbeg = left_edge(cur.rres);
		hend = right_edge(cur.rres);
		pre  = cur.tm ? int'(video_pkg::FETCH_PRE_TM) : int'(video_pkg::FETCH_PRE_ZX);
		tbeg = int'(video_pkg::HSYNC_BEG) + 2; // tile burst two dots into sync
		tend = tbeg + int'(video_pkg::TFETCH_LEN);
		e.blank = inside_span(dp, video_pkg::HBLNK_BEG, video_pkg::HBLNK_END)
			|| inside_span(l, video_pkg::VBLNK_BEG, video_pkg::VBLNK_END);
		e.hsync = inside_span(dp, video_pkg::HSYNC_BEG, video_pkg::HSYNC_END);
		e.vsync = inside_span(l, video_pkg::VSYNC_BEG, video_pkg::VSYNC_END);
		e.vpix  = inside_span(l, video_pkg::VPIX_BEG, video_pkg::VPIX_END);
		e.pix   = inside_span(dp, hbeg, hend) && e.vpix;
		e.fetch_gfx  = inside_span(dp, hbeg - pre, hend - pre) && e.vpix && !cur.brd;
		e.fetch_tile = inside_span(dp, tbeg, tend) && cur.tm
			&& inside_span(l, video_pkg::VTFETCH_BEG, video_pkg::VTFETCH_END);
		// Xscroll burst right after the tiles
		e.fetch_xs = inside_span(dp, tend, tend + int'(video_pkg::XSFETCH_LEN))
			&& (cur.tm || cur.xen);
		e.line_start   = (d == int'(video_pkg::HBLNK_END));
		e.hsync_start  = (d == int'(video_pkg::HSYNC_BEG));
		e.scanin_start = (d == int'(video_pkg::SCANIN_BEG));
		e.hint_start   = (d == int'(video_pkg::HINT_BEG));
		e.frame_int    = e.hint_start && (l == int'(cur.int_line));
		check("blank", vid.blank, e.blank);
		check("hsync", vid.hsync, e.hsync);
		check("vsync", vid.vsync, e.vsync);
		check("vpix", vid.vpix, e.vpix);
		check("pix", vid.pix, e.pix);
		check("fetch_gfx", vid.fetch_gfx, e.fetch_gfx);
		check("fetch_tile", vid.fetch_tile, e.fetch_tile);
		check("fetch_xs", vid.fetch_xs, e.fetch_xs);
		check("line_start", vid.line_start, e.line_start);
		check("hsync_start", vid.hsync_start, e.hsync_start);
		check("scanin_start", vid.scanin_start, e.scanin_start);
		check("hint_start", vid.hint_start, e.hint_start);
		check("frame_int", vid.frame_int, e.frame_int);
		cnt_pix   += vid.pix;
		cnt_gfx   += vid.fetch_gfx;
		cnt_tile  += vid.fetch_tile;
		cnt_xs    += vid.fetch_xs;
		cnt_vsync += vid.vsync;
		cnt_hs    += vid.hsync_start;
		cnt_ls    += vid.line_start;
		cnt_int   += vid.frame_int;
	endtask

	task automatic bus_write(input logic adr, input logic [15:0] data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);
		check("wb_ack", wb_ack, 1'b0); // single clock ack
	endtask

	task automatic read_back(input logic adr, output logic [15:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		data   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
		check("wb_ack", wb_ack, 1'b0);
	endtask

	// strobe driver and own dot/line position, both from reset
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			if (!phase)
			begin
				pre_cend = 1'b1;
				cend     = 1'b0;
			end
			else
			begin
				if (dot == 0 && line == 0)
				begin
					if (measure)
					begin
						measure = 1'b0;
						->frame_done;
					end
					if (arm)
					begin
						arm       = 1'b0;
						measure   = 1'b1;
						cnt_pix   = 0;
						cnt_gfx   = 0;
						cnt_tile  = 0;
						cnt_xs    = 0;
						cnt_vsync = 0;
						cnt_hs    = 0;
						cnt_ls    = 0;
						cnt_int   = 0;
					end
				end
				if (measure)
					compare_dot(dot, line);
				pre_cend = 1'b0;
				cend     = 1'b1;
				dot      = dot + 1;
				if (dot == LINE_DOTS)
				begin
					dot  = 0;
					line = (line == FRAME_LNS - 1) ? 0 : line + 1;
				end
			end
			phase = ~phase;
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CLKS)
		begin
			$display("the run timed out after %0d clocks without finishing", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [15:0] rd;
		int          w;
		cend     = 1'b0;
		pre_cend = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 1'b0;
		wb_dat_w = '0;
		phase    = 1'b0;
		dot      = 0;
		line     = 0;
		arm      = 1'b0;
		measure  = 1'b0;
		cycles   = 0;
		// rres, tiles, border, xints, interrupt line
		table_rows[0] = '{video_pkg::RRES_256,  1'b0, 1'b0, 1'b0, 9'd0};
		table_rows[1] = '{video_pkg::RRES_320A, 1'b1, 1'b0, 1'b0, 9'd100};
		table_rows[2] = '{video_pkg::RRES_320B, 1'b0, 1'b1, 1'b1, 9'd319};
		table_rows[3] = '{video_pkg::RRES_360,  1'b1, 1'b0, 1'b1, 9'd200};
		table_rows[4] = '{video_pkg::RRES_360,  1'b0, 1'b0, 1'b0, 9'd267};
		cur = table_rows[0];

		wait (arst_n === 1'b1);
		check("wb_ack", wb_ack, 1'b0);
		check("blank", vid.blank, 1'b0); // nothing opens before the first cend

		for (int r = 0; r < ROWS; r++)
		begin
			cur = table_rows[r];
			bus_write(video_pkg::REG_MODE, {11'd0, cur.xen, cur.brd, cur.tm, cur.rres});
			bus_write(video_pkg::REG_INT_LINE, {7'd0, cur.int_line});
			read_back(video_pkg::REG_MODE, rd);
			check("wb_dat_r mode", rd, {11'd0, cur.xen, cur.brd, cur.tm, cur.rres});
			read_back(video_pkg::REG_INT_LINE, rd);
			check("wb_dat_r int_line", rd, {7'd0, cur.int_line});
			arm = 1'b1;
			@(frame_done);
			w = right_edge(cur.rres) - left_edge(cur.rres);
			check("pix count", cnt_pix, VPIX_LINES * w);
			check("fetch_gfx count", cnt_gfx, cur.brd ? 0 : VPIX_LINES * w);
			check("fetch_tile count", cnt_tile,
				cur.tm ? VPIX_LINES * int'(video_pkg::TFETCH_LEN) : 0);
			check("fetch_xs count", cnt_xs,
				(cur.tm || cur.xen) ? FRAME_LNS * int'(video_pkg::XSFETCH_LEN) : 0);
			check("vsync count", cnt_vsync,
				int'(video_pkg::VSYNC_END - video_pkg::VSYNC_BEG) * LINE_DOTS);
			check("hsync_start count", cnt_hs, FRAME_LNS);
			check("line_start count", cnt_ls, FRAME_LNS);
			check("frame_int count", cnt_int, 1);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* verilog.f */
hdl/video_pkg.sv
hdl/video_cfg_regs.sv
hdl/video_sync_h.sv
hdl/video_sync_v.sv
hdl/video_sync_combine.sv
hdl/video_timing_top.sv
verification/tb_clk_gen.sv
verification/tb_video_timing.sv

/* Bender.yml */
package:
  name: video_timing

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/video_cfg_regs.sv
      - hdl/video_sync_h.sv
      - hdl/video_sync_v.sv
      - hdl/video_sync_combine.sv
      - hdl/video_timing_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_video_timing.sv
